// ==== all.f ====
+incdir+src
+incdir+verif
src/rsa_pkg.sv
src/rsa_feeder.sv
src/pe_mac.sv
src/rsa_drain.sv
src/rsa_top.sv
verif/rsa_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it, then decides on the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert -sv -Wno-fatal --top-module rsa_tb -f all.f -o rsa_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rsa_sim > sim.log 2>&1
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== src/pe_mac.sv ====
// partial sum clears while cal_en is low; a job needs one idle cycle before the next one starts
`timescale 1ns/100ps
`include "rsa_settings.svh"

module pe_mac (
    input  logic               clk,
    input  logic               sys_rst,
    input  logic               cal_en_N,
    input  logic               cal_done_N,
    input  rsa_pkg::rsa_word_t v_data_N,
    input  rsa_pkg::rsa_word_t h_data_W,
    input  logic               mulres_val_E,
    input  rsa_pkg::rsa_word_t mulres_E,
    output logic               cal_en_S,
    output logic               cal_done_S,
    output rsa_pkg::rsa_word_t v_data_S,
    output rsa_pkg::rsa_word_t h_data_E,
    output logic               mulres_val_W,
    output rsa_pkg::rsa_word_t mulres_W
);

    rsa_pkg::rsa_prod_t prod_full;
    rsa_pkg::rsa_word_t prod_word;
    rsa_pkg::rsa_word_t product;
    rsa_pkg::rsa_word_t partial_sum;

    // full signed product of both operands
    assign prod_full = rsa_pkg::rsa_prod_t'(h_data_W) * rsa_pkg::rsa_prod_t'(v_data_N);

    generate
        if (`RSA_USE_QUANT != 0) begin : g_quant
            // Q1.12.19 back to one word: keep the sign, drop surplus fraction bits
            assign prod_word = {prod_full[2*`RSA_DW-1],
                                prod_full[`RSA_INT_BIT+2*`RSA_DEC_BIT-1:`RSA_DEC_BIT]};
        end else begin : g_trunc
            // plain integer mode, wraps on overflow
            assign prod_word = prod_full[`RSA_DW-1:0];
        end
    endgenerate

    // control hops south
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            cal_en_S   <= 1'b0;
            cal_done_S <= 1'b0;
        end else begin
            cal_en_S   <= cal_en_N;
            cal_done_S <= cal_done_N;
        end
    end

    // operands move on only inside the enable window
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            v_data_S <= '0;
            h_data_E <= '0;
        end else if (cal_en_N) begin
            v_data_S <= v_data_N;
            h_data_E <= h_data_W;
        end else begin
            v_data_S <= '0;
            h_data_E <= '0;
        end
    end

    // product lags its term by one cycle
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            product <= '0;
        end else if (cal_en_N) begin
            product <= prod_word;
        end else begin
            product <= '0;
        end
    end

    // partial sum holds all terms but the last one when done arrives
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            partial_sum <= '0;
        end else if (cal_en_N && !cal_done_N) begin
            partial_sum <= partial_sum + product;
        end else begin
            partial_sum <= '0;
        end
    end

    // own result first, else pass on what comes from the east
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            mulres_val_W <= 1'b0;
            mulres_W     <= '0;
        end else begin
            mulres_val_W <= cal_done_N || mulres_val_E;
            if (cal_done_N) begin
                mulres_W <= partial_sum + product;
            end else if (mulres_val_E) begin
                mulres_W <= mulres_E;
            end else begin
                mulres_W <= '0;
            end
        end
    end

endmodule

// ==== src/rsa_drain.sv ====
// no back-pressure on res_valid; each row buffer holds one job, so jobs must not overlap
`timescale 1ns/100ps
`include "rsa_settings.svh"

module rsa_drain (
    input  logic                 clk,
    input  logic                 sys_rst,
    input  logic [`RSA_ROWS-1:0] row_val,
    input  rsa_pkg::rsa_word_t   row_res [0:`RSA_ROWS-1],
    output logic                 res_valid,
    output rsa_pkg::rsa_word_t   res_data,
    output rsa_pkg::rsa_row_t    res_row,
    output rsa_pkg::rsa_col_t    res_col,
    output logic                 job_end
);

    rsa_pkg::rsa_word_t   res_buf [0:`RSA_ROWS-1][0:`RSA_COLS-1];
    logic [`RSA_COLS-1:0] buf_vld [0:`RSA_ROWS-1];
    rsa_pkg::rsa_col_t    wr_col [0:`RSA_ROWS-1];
    rsa_pkg::rsa_row_t    rd_row;
    rsa_pkg::rsa_col_t    rd_col;
    logic                 rd_hit;
    logic                 rd_col_last;
    logic                 rd_last;

    assign rd_hit      = buf_vld[rd_row][rd_col];
    assign rd_col_last = (rd_col == rsa_pkg::rsa_col_t'(`RSA_COLS - 1));
    assign rd_last     = rd_col_last && (rd_row == rsa_pkg::rsa_row_t'(`RSA_ROWS - 1));

    genvar r;

    generate
        for (r = 0; r < `RSA_ROWS; r++) begin : g_row
            // results of a row arrive column 0 first
            always_ff @(posedge clk) begin
                if (row_val[r]) begin
                    res_buf[r][wr_col[r]] <= row_res[r];
                end
            end

            always_ff @(posedge clk) begin
                if (sys_rst) begin
                    wr_col[r]  <= '0;
                    buf_vld[r] <= '0;
                end else begin
                    if (rd_hit && (rd_row == rsa_pkg::rsa_row_t'(r))) begin
                        buf_vld[r][rd_col] <= 1'b0;
                    end
                    if (row_val[r]) begin
                        buf_vld[r][wr_col[r]] <= 1'b1;
                        if (wr_col[r] == rsa_pkg::rsa_col_t'(`RSA_COLS - 1)) begin
                            wr_col[r] <= '0;
                        end else begin
                            wr_col[r] <= wr_col[r] + 1'b1;
                        end
                    end
                end
            end
        end
    endgenerate

    // row-major read, waits on the entry under the pointer
    always_ff @(posedge clk) begin
        if (sys_rst) begin
            rd_row    <= '0;
            rd_col    <= '0;
            res_valid <= 1'b0;
            res_data  <= '0;
            res_row   <= '0;
            res_col   <= '0;
            job_end   <= 1'b0;
        end else begin
            res_valid <= rd_hit;
            job_end   <= rd_hit && rd_last;
            if (rd_hit) begin
                res_data <= res_buf[rd_row][rd_col];
                res_row  <= rd_row;
                res_col  <= rd_col;
                if (rd_last) begin
                    rd_row <= '0;
                    rd_col <= '0;
                end else if (rd_col_last) begin
                    rd_row <= rd_row + 1'b1;
                    rd_col <= '0;
                end else begin
                    rd_col <= rd_col + 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/rsa_feeder.sv ====
// one job at a time; job_k of zero is ignored and job_k above RSA_MAX_K is not supported
`timescale 1ns/100ps
`include "rsa_settings.svh"

module rsa_feeder (
    input  logic                 clk,
    input  logic                 sys_rst,
    input  logic                 job_start,
    input  rsa_pkg::rsa_k_t      job_k,
    input  rsa_pkg::rsa_word_t   a_col [0:`RSA_ROWS-1],
    input  rsa_pkg::rsa_word_t   b_row [0:`RSA_COLS-1],
    input  logic                 job_end,
    output logic                 busy,
    output rsa_pkg::rsa_word_t   h_data_W [0:`RSA_ROWS-1],
    output rsa_pkg::rsa_word_t   v_data_N [0:`RSA_COLS-1],
    output logic [`RSA_COLS-1:0] cal_en_N,
    output logic [`RSA_COLS-1:0] cal_done_N
);

    logic            accept;
    logic            in_win;
    logic            win_d;
    logic            win_end;
    rsa_pkg::rsa_k_t remain;

    // strobe taken only while idle
    assign accept  = job_start && !busy && (job_k != '0);
    // term window covers the strobe cycle and the next K-1 cycles
    assign in_win  = accept || (remain != '0);
    assign win_end = win_d && !in_win;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            busy   <= 1'b0;
            remain <= '0;
            win_d  <= 1'b0;
        end else begin
            win_d <= in_win;
            if (accept) begin
                busy   <= 1'b1;
                remain <= job_k - 1'b1;
            end else begin
                if (remain != '0) begin
                    remain <= remain - 1'b1;
                end
                // drain reports the last result of the job
                if (job_end) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    genvar r;
    genvar c;

    generate
        // row r sees its operand r cycles later than row 0
        for (r = 0; r < `RSA_ROWS; r++) begin : g_row
            rsa_pkg::rsa_word_t h_line [0:r];

            always_ff @(posedge clk) begin
                if (sys_rst) begin
                    for (int i = 0; i <= r; i++) begin
                        h_line[i] <= '0;
                    end
                end else begin
                    h_line[0] <= in_win ? a_col[r] : '0;
                    for (int i = 1; i <= r; i++) begin
                        h_line[i] <= h_line[i-1];
                    end
                end
            end

            assign h_data_W[r] = h_line[r];
        end

        // column c gets operand, enable and done c cycles later than column 0
        for (c = 0; c < `RSA_COLS; c++) begin : g_col
            rsa_pkg::rsa_word_t v_line [0:c];
            logic               en_line [0:c];
            logic               done_line [0:c];

            always_ff @(posedge clk) begin
                if (sys_rst) begin
                    for (int i = 0; i <= c; i++) begin
                        v_line[i]    <= '0;
                        en_line[i]   <= 1'b0;
                        done_line[i] <= 1'b0;
                    end
                end else begin
                    v_line[0]    <= in_win ? b_row[c] : '0;
                    en_line[0]   <= in_win;
                    // done trails the last enable by one cycle
                    done_line[0] <= win_end;
                    for (int i = 1; i <= c; i++) begin
                        v_line[i]    <= v_line[i-1];
                        en_line[i]   <= en_line[i-1];
                        done_line[i] <= done_line[i-1];
                    end
                end
            end

            assign v_data_N[c]   = v_line[c];
            assign cal_en_N[c]   = en_line[c];
            assign cal_done_N[c] = done_line[c];
        end
    endgenerate

endmodule

// ==== src/rsa_pkg.sv ====
// shared data types; all widths follow the macros in the settings header
`include "rsa_settings.svh"

package rsa_pkg;

    // index widths stay at least one bit for single-row or single-column builds
    localparam int ROW_W = (`RSA_ROWS > 1) ? $clog2(`RSA_ROWS) : 1;
    localparam int COL_W = (`RSA_COLS > 1) ? $clog2(`RSA_COLS) : 1;
    localparam int K_W   = $clog2(`RSA_MAX_K + 1);

    // data word and full product
    typedef logic signed [`RSA_DW-1:0]   rsa_word_t;
    typedef logic signed [2*`RSA_DW-1:0] rsa_prod_t;

    // term count of a job
    typedef logic [K_W-1:0] rsa_k_t;

    // result coordinates
    typedef logic [ROW_W-1:0] rsa_row_t;
    typedef logic [COL_W-1:0] rsa_col_t;

endpackage

// ==== src/rsa_settings.svh ====
// array size and number format; with RSA_USE_QUANT at 1, RSA_DW must equal 1 + INT + DEC bits
`ifndef RSA_SETTINGS_SVH
`define RSA_SETTINGS_SVH

// array geometry
`define RSA_ROWS 2
`define RSA_COLS 2

// data word and fixed-point split, sign bit on top
`define RSA_DW      32
`define RSA_INT_BIT 12
`define RSA_DEC_BIT 19

// largest term count one job may carry
`define RSA_MAX_K 16

// 1 rescales each product as Q1.12.19, 0 keeps the low product word
`define RSA_USE_QUANT 0

`endif

// ==== src/rsa_top.sv ====
// results must be taken whenever res_valid is high; job_start is ignored while busy
`timescale 1ns/100ps
`include "rsa_settings.svh"

module rsa_top (
    input  logic               clk,
    input  logic               sys_rst,
    input  logic               job_start,
    input  rsa_pkg::rsa_k_t    job_k,
    input  rsa_pkg::rsa_word_t a_col [0:`RSA_ROWS-1],
    input  rsa_pkg::rsa_word_t b_row [0:`RSA_COLS-1],
    output logic               busy,
    output logic               res_valid,
    output rsa_pkg::rsa_word_t res_data,
    output rsa_pkg::rsa_row_t  res_row,
    output rsa_pkg::rsa_col_t  res_col,
    output logic               job_end
);

    rsa_pkg::rsa_word_t   edge_h [0:`RSA_ROWS-1];
    rsa_pkg::rsa_word_t   edge_v [0:`RSA_COLS-1];
    logic [`RSA_COLS-1:0] edge_en;
    logic [`RSA_COLS-1:0] edge_done;

    // grid nets, one extra tap on the east and south edges
    rsa_pkg::rsa_word_t   h_w [0:`RSA_ROWS-1][0:`RSA_COLS];
    rsa_pkg::rsa_word_t   v_w [0:`RSA_ROWS][0:`RSA_COLS-1];
    logic                 en_w [0:`RSA_ROWS][0:`RSA_COLS-1];
    logic                 done_w [0:`RSA_ROWS][0:`RSA_COLS-1];
    logic                 mv_w [0:`RSA_ROWS-1][0:`RSA_COLS];
    rsa_pkg::rsa_word_t   mr_w [0:`RSA_ROWS-1][0:`RSA_COLS];
    logic [`RSA_ROWS-1:0] row_val;
    rsa_pkg::rsa_word_t   row_res [0:`RSA_ROWS-1];

    rsa_feeder feeder_i (
        .clk        (clk),
        .sys_rst    (sys_rst),
        .job_start  (job_start),
        .job_k      (job_k),
        .a_col      (a_col),
        .b_row      (b_row),
        .job_end    (job_end),
        .busy       (busy),
        .h_data_W   (edge_h),
        .v_data_N   (edge_v),
        .cal_en_N   (edge_en),
        .cal_done_N (edge_done)
    );

    genvar r;
    genvar c;

    generate
        for (r = 0; r < `RSA_ROWS; r++) begin : g_row
            assign h_w[r][0] = edge_h[r];
            // nothing enters from the east edge
            assign mv_w[r][`RSA_COLS] = 1'b0;
            assign mr_w[r][`RSA_COLS] = '0;
            assign row_val[r] = mv_w[r][0];
            assign row_res[r] = mr_w[r][0];
        end

        for (c = 0; c < `RSA_COLS; c++) begin : g_col
            assign v_w[0][c]    = edge_v[c];
            assign en_w[0][c]   = edge_en[c];
            assign done_w[0][c] = edge_done[c];
        end

        for (r = 0; r < `RSA_ROWS; r++) begin : g_pe_row
            for (c = 0; c < `RSA_COLS; c++) begin : g_pe_col
                pe_mac pe_i (
                    .clk          (clk),
                    .sys_rst      (sys_rst),
                    .cal_en_N     (en_w[r][c]),
                    .cal_done_N   (done_w[r][c]),
                    .v_data_N     (v_w[r][c]),
                    .h_data_W     (h_w[r][c]),
                    .mulres_val_E (mv_w[r][c+1]),
                    .mulres_E     (mr_w[r][c+1]),
                    .cal_en_S     (en_w[r+1][c]),
                    .cal_done_S   (done_w[r+1][c]),
                    .v_data_S     (v_w[r+1][c]),
                    .h_data_E     (h_w[r][c+1]),
                    .mulres_val_W (mv_w[r][c]),
                    .mulres_W     (mr_w[r][c])
                );
            end
        end
    endgenerate

    rsa_drain drain_i (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .row_val   (row_val),
        .row_res   (row_res),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_row   (res_row),
        .res_col   (res_col),
        .job_end   (job_end)
    );

endmodule

// ==== verif/rsa_tb_tasks.svh ====
// directed tests, included inside the testbench module; operands scaled so Q1.12.19 stays nonzero
`ifndef RSA_TB_TASKS_SVH
`define RSA_TB_TASKS_SVH

// nothing may come out before the first strobe
task automatic idle_after_reset();
    repeat (20) begin
        @(negedge clk);
        check_value("idle_after_reset", "busy", 0, longint'(busy));
        check_value("idle_after_reset", "res_valid", 0, longint'(res_valid));
        check_value("idle_after_reset", "job_end", 0, longint'(job_end));
    end
endtask

task automatic single_term_job();
    int r;
    int c;
    for (r = 0; r < `RSA_ROWS; r++) begin
        a_mat[r][0] = rsa_pkg::rsa_word_t'((r + 2) * 1024);
    end
    for (c = 0; c < `RSA_COLS; c++) begin
        b_mat[0][c] = rsa_pkg::rsa_word_t'((c + 3) * 1024);
    end
    drive_job(1);
    check_results("single_term_job", 1);
endtask

task automatic random_max_k_job();
    int r;
    int c;
    int t;
    for (t = 0; t < `RSA_MAX_K; t++) begin
        for (r = 0; r < `RSA_ROWS; r++) begin
            a_mat[r][t] = rsa_pkg::rsa_word_t'($urandom());
        end
        for (c = 0; c < `RSA_COLS; c++) begin
            b_mat[t][c] = rsa_pkg::rsa_word_t'($urandom());
        end
    end
    drive_job(`RSA_MAX_K);
    check_results("random_max_k_job", `RSA_MAX_K);
endtask

// second strobe lands while the first job drains and must be dropped
task automatic back_to_back_jobs();
    int r;
    int c;
    int t;
    for (t = 0; t < 5; t++) begin
        for (r = 0; r < `RSA_ROWS; r++) begin
            a_mat[r][t] = rsa_pkg::rsa_word_t'((r * 10 + t + 1) * 1024);
        end
        for (c = 0; c < `RSA_COLS; c++) begin
            b_mat[t][c] = rsa_pkg::rsa_word_t'((t * 3 - c + 2) * 1024);
        end
    end
    drive_job(5);
    @(negedge clk);
    check_value("back_to_back_jobs", "busy before extra strobe", 1, longint'(busy));
    @(posedge clk);
    job_start <= 1'b1;
    job_k     <= rsa_pkg::rsa_k_t'(`RSA_MAX_K);
    for (r = 0; r < `RSA_ROWS; r++) begin
        a_col[r] <= rsa_pkg::rsa_word_t'(999);
    end
    @(posedge clk);
    job_start <= 1'b0;
    for (r = 0; r < `RSA_ROWS; r++) begin
        a_col[r] <= '0;
    end
    check_results("back_to_back_jobs first", 5);

    for (t = 0; t < 3; t++) begin
        for (r = 0; r < `RSA_ROWS; r++) begin
            a_mat[r][t] = rsa_pkg::rsa_word_t'((7 - t - r) * 1024);
        end
        for (c = 0; c < `RSA_COLS; c++) begin
            b_mat[t][c] = rsa_pkg::rsa_word_t'((c + t + 1) * 1024);
        end
    end
    drive_job(3);
    check_results("back_to_back_jobs second", 3);
endtask

task automatic mixed_sign_job();
    int r;
    int c;
    int t;
    for (t = 0; t < 6; t++) begin
        for (r = 0; r < `RSA_ROWS; r++) begin
            a_mat[r][t] = rsa_pkg::rsa_word_t'(((t % 2 == 0) ? -1 : 1) * (r + t + 1) * 1024);
        end
        for (c = 0; c < `RSA_COLS; c++) begin
            b_mat[t][c] = rsa_pkg::rsa_word_t'(((c % 2 == 1) ? -1 : 1) * (t - 2) * 1024);
        end
    end
    drive_job(6);
    check_results("mixed_sign_job", 6);
endtask

`endif

// ==== verif/rsa_tb.sv ====
// stops at the first mismatch; expected values come from a dot-product model of the job
`timescale 1ns/100ps
`include "rsa_settings.svh"

module rsa_tb;

    localparam int NUM_RES    = `RSA_ROWS * `RSA_COLS;
    localparam int RST_CYCLES = 16;
    // one job at RSA_MAX_K covers feed, skew across the grid, drain and some slack
    localparam int JOB_CYCLES = `RSA_MAX_K + `RSA_ROWS + `RSA_COLS + NUM_RES + 8;
    localparam int NUM_JOBS   = 6;
    localparam int CYCLE_LIMIT = 4 * (RST_CYCLES + 20 + (NUM_JOBS + 1) * JOB_CYCLES);

    logic               clk;
    logic               sys_rst;
    logic               job_start;
    rsa_pkg::rsa_k_t    job_k;
    rsa_pkg::rsa_word_t a_col [0:`RSA_ROWS-1];
    rsa_pkg::rsa_word_t b_row [0:`RSA_COLS-1];
    logic               busy;
    logic               res_valid;
    rsa_pkg::rsa_word_t res_data;
    rsa_pkg::rsa_row_t  res_row;
    rsa_pkg::rsa_col_t  res_col;
    logic               job_end;

    // operands of the current job with A as ROWS x K and B as K x COLS
    rsa_pkg::rsa_word_t a_mat [0:`RSA_ROWS-1][0:`RSA_MAX_K-1];
    rsa_pkg::rsa_word_t b_mat [0:`RSA_MAX_K-1][0:`RSA_COLS-1];

    // result stream collected by the monitor
    rsa_pkg::rsa_word_t data_q [$];
    rsa_pkg::rsa_row_t  row_q [$];
    rsa_pkg::rsa_col_t  col_q [$];
    logic               end_q [$];

    int cycle_cnt  = 0;
    int result_cnt = 0;
    int jobs_sent  = 0;

    rsa_top dut_i (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .job_start (job_start),
        .job_k     (job_k),
        .a_col     (a_col),
        .b_row     (b_row),
        .busy      (busy),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_row   (res_row),
        .res_col   (res_col),
        .job_end   (job_end)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string test_name, input string what,
                               input longint expected, input longint actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            stop_on_error();
        end
    end

    // registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!sys_rst) begin
            assert (res_valid || !job_end) else begin
                $display("job_end pulsed without a result beside it");
                stop_on_error();
            end
            if (res_valid) begin
                data_q.push_back(res_data);
                row_q.push_back(res_row);
                col_q.push_back(res_col);
                end_q.push_back(job_end);
                result_cnt = result_cnt + 1;
            end
        end
    end

    // product of two words as the PE keeps it in integer or Q1.12.19 form
    function automatic rsa_pkg::rsa_word_t scaled_product(input rsa_pkg::rsa_word_t a,
                                                          input rsa_pkg::rsa_word_t b);
        rsa_pkg::rsa_prod_t p;
        rsa_pkg::rsa_prod_t shifted;
        p = a;
        p = p * b;
        if (`RSA_USE_QUANT != 0) begin
            // drop 19 of the 38 fraction bits and keep the sign
            shifted = p >>> `RSA_DEC_BIT;
            return {p[2*`RSA_DW-1], shifted[`RSA_DW-2:0]};
        end
        return p[`RSA_DW-1:0];
    endfunction

    function automatic rsa_pkg::rsa_word_t expected_dot(input int r, input int c, input int k);
        rsa_pkg::rsa_word_t acc;
        int t;
        acc = '0;
        for (t = 0; t < k; t++) begin
            acc = acc + scaled_product(a_mat[r][t], b_mat[t][c]);
        end
        return acc;
    endfunction

    // one column of A and one row of B per cycle with the strobe on the first term
    task automatic drive_job(input int k);
        int t;
        int i;
        for (t = 0; t < k; t++) begin
            @(posedge clk);
            job_start <= (t == 0);
            job_k     <= rsa_pkg::rsa_k_t'(k);
            for (i = 0; i < `RSA_ROWS; i++) begin
                a_col[i] <= a_mat[i][t];
            end
            for (i = 0; i < `RSA_COLS; i++) begin
                b_row[i] <= b_mat[t][i];
            end
        end
        @(posedge clk);
        job_start <= 1'b0;
        for (i = 0; i < `RSA_ROWS; i++) begin
            a_col[i] <= '0;
        end
        for (i = 0; i < `RSA_COLS; i++) begin
            b_row[i] <= '0;
        end
        jobs_sent = jobs_sent + 1;
    endtask

    // row-major stream with job_end only on the very last element
    task automatic check_results(input string test_name, input int k);
        int r;
        int c;
        while (data_q.size() < NUM_RES) begin
            @(posedge clk);
        end
        for (r = 0; r < `RSA_ROWS; r++) begin
            for (c = 0; c < `RSA_COLS; c++) begin
                check_value(test_name, "res_row", longint'(r), longint'(row_q.pop_front()));
                check_value(test_name, "res_col", longint'(c), longint'(col_q.pop_front()));
                check_value(test_name, "res_data", longint'(expected_dot(r, c, k)),
                            longint'(data_q.pop_front()));
                check_value(test_name, "job_end",
                            longint'((r == `RSA_ROWS-1) && (c == `RSA_COLS-1)),
                            longint'(end_q.pop_front()));
            end
        end
        while (busy) begin
            @(negedge clk);
        end
    endtask

`include "rsa_tb_tasks.svh"

    initial begin
        sys_rst   = 1'b1;
        job_start = 1'b0;
        job_k     = '0;
        for (int i = 0; i < `RSA_ROWS; i++) begin
            a_col[i] = '0;
        end
        for (int i = 0; i < `RSA_COLS; i++) begin
            b_row[i] = '0;
        end
        void'($urandom(32'h6a4a1bf6));
        repeat (RST_CYCLES) @(posedge clk);
        sys_rst <= 1'b0;

        idle_after_reset();
        single_term_job();
        random_max_k_job();
        back_to_back_jobs();
        mixed_sign_job();

        repeat (JOB_CYCLES) @(posedge clk);
        check_value("end of run", "result count", longint'(NUM_RES * jobs_sent),
                    longint'(result_cnt));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
